// File: files.f
logic/cpu_pkg.sv
logic/pipe_if.sv
logic/register_file.sv
logic/decode_stage.sv
logic/forwarding_unit.sv
logic/alu.sv
logic/execute_stage.sv
logic/cpu_core.sv
testbench/tb_cpu_core.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - logic/cpu_pkg.sv
  - logic/pipe_if.sv
  - logic/register_file.sv
  - logic/decode_stage.sv
  - logic/forwarding_unit.sv
  - logic/alu.sv
  - logic/execute_stage.sv
  - logic/cpu_core.sv
  - target: test
    files:
      - testbench/tb_cpu_core.sv

// File: testbench/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;
  import cpu_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int N_RANDOM   = 200;
  localparam int N_CHAIN    = 60;
  localparam int N_STALL    = 200;
  localparam int N_ZERO     = 8;
  localparam int N_UNKNOWN  = 12;
  // two chain passes, four fixed r0 reads, one readback per unknown op
  localparam int TOTAL_INSTR = 3 + N_RANDOM + 2 * N_CHAIN + N_STALL + N_ZERO + 4 + 2 * N_UNKNOWN;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  instr_t                in_instr;
  logic                  res_valid;
  logic                  res_ready;
  logic                  res_write;
  logic [REG_ADDR_W-1:0] res_dst;
  logic [DATA_W-1:0]     res_data;

  logic [DATA_W-1:0]     model_regs [NUM_REGS];
  logic [DATA_W-1:0]     exp_data_q [$];
  logic [REG_ADDR_W-1:0] exp_dst_q [$];
  logic                  exp_write_q [$];
  logic                  exp_known_q [$];
  string                 exp_name_q [$];
  string                 test_name;
  logic [31:0]           stim_state;
  logic [31:0]           bp_state;
  logic                  bp_mode;
  int                    low_left;
  logic                  was_stalled;
  logic                  held_write;
  logic [REG_ADDR_W-1:0] held_dst;
  logic [DATA_W-1:0]     held_data;
  int                    value_errors;
  int                    order_errors;

  cpu_core u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_instr  (in_instr),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_write (res_write),
    .res_dst   (res_dst),
    .res_data  (res_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((TOTAL_INSTR * 8 + 200) * CLK_PERIOD);
    $display("watchdog expired before all results came back");
    $display("test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // random numbers and instruction building
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    stim_state = lcg_step(stim_state);
    return stim_state[31:16] % n;
  endfunction

  function automatic logic is_itype(input logic [OPCODE_W-1:0] op);
    return (op == OP_ADDI) || (op == OP_ANDI) || (op == OP_ORI);
  endfunction

  // r-type codes are contiguous from add to sll
  function automatic logic is_known(input logic [OPCODE_W-1:0] op);
    return is_itype(op) || ((op >= OP_ADD) && (op <= OP_SLL));
  endfunction

  function automatic logic [OPCODE_W-1:0] pick_op(input int unsigned idx);
    if (idx < 7) return OP_ADD + idx;
    return (idx == 7) ? OP_ADDI : (idx == 8) ? OP_ANDI : OP_ORI;
  endfunction

  function automatic instr_t make_r(input logic [OPCODE_W-1:0] op,
                                    input logic [REG_ADDR_W-1:0] rs, rt, rd,
                                    input logic [SHAMT_W-1:0] shamt);
    instr_t ins;
    ins = '0;
    ins.r.opcode = op;
    ins.r.rs     = rs;
    ins.r.rt     = rt;
    ins.r.rd     = rd;
    ins.r.shamt  = shamt;
    return ins;
  endfunction

  function automatic instr_t make_i(input logic [OPCODE_W-1:0] op,
                                    input logic [REG_ADDR_W-1:0] rs, rt,
                                    input logic [IMM_W-1:0] imm);
    instr_t ins;
    ins.i.opcode = op;
    ins.i.rs     = rs;
    ins.i.rt     = rt;
    ins.i.imm    = imm;
    return ins;
  endfunction

  function automatic instr_t random_instr(input int unsigned span);
    logic [OPCODE_W-1:0] op;
    op = pick_op(rand_below(10));
    if (is_itype(op)) return make_i(op, rand_below(span), rand_below(span), rand_below(65536));
    return make_r(op, rand_below(span), rand_below(span), rand_below(span), rand_below(32));
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] exp_result(input instr_t ins);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] imm;
    a   = model_regs[ins.r.rs];
    b   = model_regs[ins.r.rt];
    imm = {{(DATA_W-IMM_W){1'b0}}, ins.i.imm};
    case (ins.r.opcode)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      OP_SLL:  return b << ins.r.shamt;
      OP_ADDI: return a + imm;
      OP_ANDI: return a & imm;
      OP_ORI:  return a | imm;
      default: return '0;
    endcase
  endfunction

  task automatic push_expected(input instr_t ins);
    logic [REG_ADDR_W-1:0] dst;
    logic [DATA_W-1:0]     data;
    logic                  wr;
    dst  = is_itype(ins.r.opcode) ? ins.i.rt : ins.r.rd;
    data = exp_result(ins);
    wr   = is_known(ins.r.opcode) && (dst != '0);
    if (wr) model_regs[dst] = data;
    exp_data_q.push_back(data);
    exp_dst_q.push_back(dst);
    exp_write_q.push_back(wr);
    exp_known_q.push_back(is_known(ins.r.opcode));
    exp_name_q.push_back(test_name);
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string what, input logic [DATA_W-1:0] exp, act);
    if (act !== exp) begin
      $display("Error %s: expected %h, actual %h", what, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_dst(input string what, input logic [REG_ADDR_W-1:0] exp, act);
    if (act !== exp) begin
      $display("Error %s: expected %0d, actual %0d", what, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, act);
    if (act !== exp) begin
      $display("Error %s: expected %b, actual %b", what, exp, act);
      value_errors++;
    end
  endtask

  // outputs settle by the falling edge before the next handoff
  always @(negedge clk) begin : compare
    string name;
    if (rst_n) begin
      if (was_stalled) begin
        check_flag({test_name, " held res_valid"}, 1'b1, res_valid);
        check_flag({test_name, " held res_write"}, held_write, res_write);
        check_dst({test_name, " held res_dst"}, held_dst, res_dst);
        check_data({test_name, " held res_data"}, held_data, res_data);
      end
      if (res_valid && res_ready) begin
        if (exp_name_q.size() == 0) begin
          $display("a result came out with no instruction outstanding");
          order_errors++;
        end else begin
          name = exp_name_q.pop_front();
          check_flag({name, " res_write"}, exp_write_q.pop_front(), res_write);
          if (exp_known_q.pop_front()) begin
            check_dst({name, " res_dst"}, exp_dst_q.pop_front(), res_dst);
            check_data({name, " res_data"}, exp_data_q.pop_front(), res_data);
          end else begin
            void'(exp_dst_q.pop_front());
            void'(exp_data_q.pop_front());
          end
        end
      end
      was_stalled = res_valid && !res_ready;
      held_write  = res_write;
      held_dst    = res_dst;
      held_data   = res_data;
    end
  end

  // back-pressure with low runs of one to eight cycles
  always @(posedge clk) begin
    if (!bp_mode) begin
      res_ready <= 1'b1;
      low_left = 0;
    end else if (low_left != 0) begin
      res_ready <= 1'b0;
      low_left--;
    end else begin
      bp_state = lcg_step(bp_state);
      res_ready <= (bp_state[31:30] != 2'd0);
      if (bp_state[31:30] == 2'd0) low_left = bp_state[29:27];
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // called just after a rising edge, returns just after the accepting edge
  task automatic send_instr(input instr_t ins);
    in_valid <= 1'b1;
    in_instr <= ins;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    push_expected(ins);
    @(posedge clk);
  endtask

  task automatic idle_cycles(input int unsigned n);
    in_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic end_test();
    in_valid <= 1'b0;
    for (int i = 0; (i < 200) && (exp_name_q.size() != 0); i++) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic run_reset_test();
    test_name = "reset";
    @(negedge clk);
    check_flag("reset res_valid", 1'b0, res_valid);
    check_flag("reset in_ready", 1'b1, in_ready);
    @(posedge clk);
    send_instr(make_r(OP_ADD, 5'd1, 5'd2, 5'd3, 5'd0));
    send_instr(make_r(OP_SUB, 5'd4, 5'd5, 5'd6, 5'd0));
    send_instr(make_i(OP_ORI, 5'd7, 5'd8, 16'h1234));
    end_test();
  endtask

  task automatic run_stream_test(input string name, input int n, input int unsigned span);
    test_name = name;
    for (int i = 0; i < n; i++) begin
      send_instr(random_instr(span));
      if (rand_below(4) == 0) idle_cycles(rand_below(3) + 1);
    end
    end_test();
  endtask

  // each source is the previous destination or the one before it
  task automatic run_chain_test(input int unsigned max_gap);
    logic [REG_ADDR_W-1:0] d1;
    logic [REG_ADDR_W-1:0] d2;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] dst;
    logic [OPCODE_W-1:0]   op;
    int unsigned           gap;
    test_name = (max_gap == 0) ? "chain" : "chain with gaps";
    d1 = 5'd9;
    d2 = 5'd10;
    for (int i = 0; i < N_CHAIN; i++) begin
      op  = pick_op(rand_below(10));
      rs  = rand_below(2) ? d1 : d2;
      rt  = rand_below(2) ? d1 : d2;
      dst = rand_below(31) + 1;
      if (is_itype(op)) send_instr(make_i(op, rs, dst, rand_below(65536)));
      else send_instr(make_r(op, rs, rt, dst, rand_below(32)));
      d2 = d1;
      d1 = dst;
      gap = rand_below(max_gap + 1);
      if (gap != 0) idle_cycles(gap);
    end
    end_test();
  endtask

  task automatic run_zero_test();
    instr_t              ins;
    logic [OPCODE_W-1:0] op;
    test_name = "r0 destination";
    for (int i = 0; i < N_ZERO; i++) begin
      op = pick_op(rand_below(10));
      if (is_itype(op)) send_instr(make_i(op, rand_below(32), 5'd0, rand_below(65536)));
      else send_instr(make_r(op, rand_below(32), rand_below(32), 5'd0, rand_below(32)));
    end
    send_instr(make_r(OP_ADD, 5'd0, 5'd0, 5'd11, 5'd0));
    send_instr(make_r(OP_OR, 5'd0, 5'd0, 5'd12, 5'd0));
    send_instr(make_i(OP_ADDI, 5'd0, 5'd13, 16'h00ff));
    send_instr(make_r(OP_SLL, 5'd0, 5'd0, 5'd14, 5'd3));
    test_name = "unknown opcode";
    for (int i = 0; i < N_UNKNOWN; i++) begin
      ins = random_instr(32);
      op  = rand_below(64);
      while (is_known(op)) op = rand_below(64);
      ins.r.opcode = op;
      send_instr(ins);
      // both possible targets read back unchanged
      send_instr(make_r(OP_OR, ins.r.rd, ins.i.rt, rand_below(31) + 1, 5'd0));
    end
    end_test();
  endtask

  initial begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_instr     = '0;
    res_ready    = 1'b1;
    bp_mode      = 1'b0;
    low_left     = 0;
    stim_state   = 32'hf825_f4cf;
    bp_state     = 32'hf825_f4cf;
    was_stalled  = 1'b0;
    value_errors = 0;
    order_errors = 0;
    test_name    = "reset";
    for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    run_reset_test();
    run_stream_test("random", N_RANDOM, 32);
    run_chain_test(0);
    run_chain_test(2);
    bp_mode <= 1'b1;
    // small register span keeps dependencies frequent
    run_stream_test("back-pressure", N_STALL, 8);
    bp_mode <= 1'b0;
    run_zero_test();
    if (exp_name_q.size() != 0) begin
      $display("%0d accepted instructions never produced a result", exp_name_q.size());
      order_errors += exp_name_q.size();
    end
    $display("errors: %0d wrong values, %0d missing or extra results",
             value_errors, order_errors);
    if ((value_errors + order_errors) == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
  input  logic                           clk,
  input  logic                           rst_n,
  // instruction stream
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [cpu_pkg::DATA_W-1:0]     in_instr,
  // results in program order
  output logic                           res_valid,
  input  logic                           res_ready,
  output logic                           res_write,
  output logic [cpu_pkg::REG_ADDR_W-1:0] res_dst,
  output logic [cpu_pkg::DATA_W-1:0]     res_data
);

  dx_if dx_bus ();
  wb_if wb_bus ();

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  decode_stage u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_instr (in_instr),
    .dx       (dx_bus.decode),
    .wb       (wb_bus.sink)
  );

  ////////////////////////////////////////////////////////////
  // execute and result port
  ////////////////////////////////////////////////////////////

  execute_stage u_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .dx        (dx_bus.execute),
    .wb        (wb_bus.source),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_write (res_write),
    .res_dst   (res_dst),
    .res_data  (res_data)
  );

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  dx_if.execute                          dx,
  wb_if.source                           wb,
  output logic                           res_valid,
  input  logic                           res_ready,
  output logic                           res_write,
  output logic [cpu_pkg::REG_ADDR_W-1:0] res_dst,
  output logic [cpu_pkg::DATA_W-1:0]     res_data
);
  import cpu_pkg::*;

  logic                  advance;
  logic                  ex_valid;
  logic                  ex_reg_write;
  logic                  ex_use_imm;
  logic [ALU_OP_W-1:0]   ex_alu_op;
  logic [REG_ADDR_W-1:0] ex_rs;
  logic [REG_ADDR_W-1:0] ex_rt;
  logic [REG_ADDR_W-1:0] ex_dst;
  logic [IMM_W-1:0]      ex_imm;
  logic [SHAMT_W-1:0]    ex_shamt;
  logic [DATA_W-1:0]     ex_rs_data;
  logic [DATA_W-1:0]     ex_rt_data;
  logic                  fwd_rs;
  logic                  fwd_rt;
  logic [DATA_W-1:0]     op_a;
  logic [DATA_W-1:0]     rt_val;
  logic [DATA_W-1:0]     op_b;
  logic [DATA_W-1:0]     alu_result;

  // stall only while a result waits on the port
  assign advance  = !res_valid || res_ready;
  assign dx.ready = advance;

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
    end else if (advance) begin
      ex_valid     <= dx.valid;
      ex_reg_write <= dx.valid && dx.reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && dx.valid) begin
      ex_use_imm <= dx.use_imm;
      ex_alu_op  <= dx.alu_op;
      ex_rs      <= dx.rs;
      ex_rt      <= dx.rt;
      ex_dst     <= dx.dst;
      ex_imm     <= dx.imm;
      ex_shamt   <= dx.shamt;
      ex_rs_data <= dx.rs_data;
      ex_rt_data <= dx.rt_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // operands and alu
  ////////////////////////////////////////////////////////////

  forwarding_unit u_fwd (
    .rs       (ex_rs),
    .rt       (ex_rt),
    .wb_valid (res_valid),
    .wb_write (res_write),
    .wb_dst   (res_dst),
    .fwd_rs   (fwd_rs),
    .fwd_rt   (fwd_rt)
  );

  assign op_a   = fwd_rs ? res_data : ex_rs_data;
  assign rt_val = fwd_rt ? res_data : ex_rt_data;
  // zero-extended immediate
  assign op_b   = ex_use_imm ? {{(DATA_W-IMM_W){1'b0}}, ex_imm} : rt_val;

  alu u_alu (
    .alu_op (ex_alu_op),
    .a      (op_a),
    .b      (op_b),
    .shamt  (ex_shamt),
    .result (alu_result)
  );

  ////////////////////////////////////////////////////////////
  // result register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      res_write <= 1'b0;
    end else if (advance) begin
      res_valid <= ex_valid;
      res_write <= ex_valid && ex_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && ex_valid) begin
      res_dst  <= ex_dst;
      res_data <= alu_result;
    end
  end

  // register file takes the result on handoff
  assign wb.commit = res_valid && res_ready && res_write;
  assign wb.dst    = res_dst;
  assign wb.data   = res_data;

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [cpu_pkg::ALU_OP_W-1:0] alu_op,
  input  logic [cpu_pkg::DATA_W-1:0]   a,
  input  logic [cpu_pkg::DATA_W-1:0]   b,
  input  logic [cpu_pkg::SHAMT_W-1:0]  shamt,
  output logic [cpu_pkg::DATA_W-1:0]   result
);
  import cpu_pkg::*;

  logic lt;

  // signed compare for slt
  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = {{(DATA_W-1){1'b0}}, lt};
      // shifts the rt operand
      ALU_SLL: result = b << shamt;
      default: result = '0;
    endcase
  end

endmodule

// File: logic/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit (
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rs,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rt,
  input  logic                           wb_valid,
  input  logic                           wb_write,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_dst,
  output logic                           fwd_rs,
  output logic                           fwd_rt
);

  logic wb_live;

  // result register holds a real write to a nonzero register
  assign wb_live = wb_valid && wb_write && (wb_dst != '0);

  // newer value still sitting in the result register
  assign fwd_rs = wb_live && (wb_dst == rs);
  assign fwd_rt = wb_live && (wb_dst == rt);

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  cpu_pkg::instr_t in_instr,
  dx_if.decode            dx,
  wb_if.sink              wb
);
  import cpu_pkg::*;

  instr_t                if_instr;
  logic                  if_valid;
  logic [ALU_OP_W-1:0]   alu_op;
  logic                  use_imm;
  logic                  known_op;
  logic [REG_ADDR_W-1:0] dst;

  // whole pipe moves together
  assign in_ready = dx.ready;

  ////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_valid <= 1'b0;
    end else if (in_ready) begin
      if_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      if_instr <= in_instr;
    end
  end

  ////////////////////////////////////////////////////////////
  // control decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_op   = ALU_ADD;
    use_imm  = 1'b0;
    known_op = 1'b1;
    case (if_instr.r.opcode)
      OP_ADD:  alu_op = ALU_ADD;
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_XOR:  alu_op = ALU_XOR;
      OP_SLT:  alu_op = ALU_SLT;
      OP_SLL:  alu_op = ALU_SLL;
      OP_ADDI: begin
        alu_op  = ALU_ADD;
        use_imm = 1'b1;
      end
      OP_ANDI: begin
        alu_op  = ALU_AND;
        use_imm = 1'b1;
      end
      OP_ORI: begin
        alu_op  = ALU_OR;
        use_imm = 1'b1;
      end
      // unknown opcode becomes a no-op
      default: known_op = 1'b0;
    endcase
  end

  // rt is the target for i-type
  assign dst = use_imm ? if_instr.i.rt : if_instr.r.rd;

  register_file u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .write_en   (wb.commit),
    .write_addr (wb.dst),
    .write_data (wb.data),
    .rs_addr    (if_instr.i.rs),
    .rt_addr    (if_instr.i.rt),
    .rs_data    (dx.rs_data),
    .rt_data    (dx.rt_data)
  );

  assign dx.valid     = if_valid;
  assign dx.alu_op    = alu_op;
  assign dx.rs        = if_instr.i.rs;
  assign dx.rt        = if_instr.i.rt;
  assign dx.dst       = dst;
  assign dx.reg_write = known_op && (dst != '0);
  assign dx.use_imm   = use_imm;
  assign dx.imm       = if_instr.i.imm;
  assign dx.shamt     = if_instr.r.shamt;

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           write_en,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] write_addr,
  input  logic [cpu_pkg::DATA_W-1:0]     write_data,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr,
  output logic [cpu_pkg::DATA_W-1:0]     rs_data,
  output logic [cpu_pkg::DATA_W-1:0]     rt_data
);
  import cpu_pkg::*;

  logic [DATA_W-1:0] regs [NUM_REGS];

  // writes to r0 are dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (write_addr != '0)) begin
      regs[write_addr] <= write_data;
    end
  end

  // r0 reads zero
  // a write in the same cycle bypasses the array
  assign rs_data = (rs_addr == '0) ? '0 :
                   (write_en && (write_addr == rs_addr)) ? write_data :
                   regs[rs_addr];

  assign rt_data = (rt_addr == '0) ? '0 :
                   (write_en && (write_addr == rt_addr)) ? write_data :
                   regs[rt_addr];

endmodule

// File: logic/pipe_if.sv
`timescale 1ns/1ps

// decode to execute payload qualified by valid
interface dx_if;
  import cpu_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [ALU_OP_W-1:0]   alu_op;
  logic [REG_ADDR_W-1:0] rs;
  logic [REG_ADDR_W-1:0] rt;
  logic [REG_ADDR_W-1:0] dst;
  logic                  reg_write;
  logic                  use_imm;
  logic [IMM_W-1:0]      imm;
  logic [SHAMT_W-1:0]    shamt;
  logic [DATA_W-1:0]     rs_data;
  logic [DATA_W-1:0]     rt_data;

  modport decode (
    output valid, alu_op, rs, rt, dst, reg_write, use_imm, imm, shamt, rs_data, rt_data,
    input  ready
  );

  modport execute (
    input  valid, alu_op, rs, rt, dst, reg_write, use_imm, imm, shamt, rs_data, rt_data,
    output ready
  );
endinterface

// register file write back from the result port
interface wb_if;
  import cpu_pkg::*;

  logic                  commit;
  logic [REG_ADDR_W-1:0] dst;
  logic [DATA_W-1:0]     data;

  modport source (output commit, dst, data);
  modport sink (input commit, dst, data);
endinterface

// File: logic/cpu_pkg.sv
package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int SHAMT_W    = 5;
  localparam int IMM_W      = 16;
  localparam int OPCODE_W   = 6;
  localparam int ALU_OP_W   = 3;

  ////////////////////////////////////////////////////////////
  // opcodes
  ////////////////////////////////////////////////////////////

  // register-register
  localparam logic [OPCODE_W-1:0] OP_ADD  = 6'h01;
  localparam logic [OPCODE_W-1:0] OP_SUB  = 6'h02;
  localparam logic [OPCODE_W-1:0] OP_AND  = 6'h03;
  localparam logic [OPCODE_W-1:0] OP_OR   = 6'h04;
  localparam logic [OPCODE_W-1:0] OP_XOR  = 6'h05;
  localparam logic [OPCODE_W-1:0] OP_SLT  = 6'h06;
  localparam logic [OPCODE_W-1:0] OP_SLL  = 6'h07;
  // register-immediate with zero-extended immediate
  localparam logic [OPCODE_W-1:0] OP_ADDI = 6'h08;
  localparam logic [OPCODE_W-1:0] OP_ANDI = 6'h0c;
  localparam logic [OPCODE_W-1:0] OP_ORI  = 6'h0d;

  // alu operation codes
  localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SLL = 3'd6;

  // one instruction word in two field layouts
  typedef union packed {
    struct packed {
      logic [OPCODE_W-1:0]   opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [SHAMT_W-1:0]    shamt;
      logic [5:0]            unused;
    } r;
    struct packed {
      logic [OPCODE_W-1:0]   opcode;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [IMM_W-1:0]      imm;
    } i;
  } instr_t;

endpackage
